// ==== logic/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define CORE_XLEN 32

// Architectural integer registers, r0 hardwired to zero
`define CORE_NUM_REGS 32

// Instructions returned by one memory answer
`define CORE_FETCH_WIDTH 2

// Instruction buffer slots, power of two
`define CORE_IB_DEPTH 8

// Boot address of the LA32R core
`define CORE_RESET_PC 32'h1c000000

`endif

// ==== logic/core_pkg.sv ====
`include "core_defines.svh"

package core_pkg;

    // Instruction fetch address
    typedef logic [`CORE_XLEN-1:0] addr_t;

    // LA32R encodings are always one word
    typedef logic [31:0] instr_t;

    // Register file value
    typedef logic [`CORE_XLEN-1:0] data_t;

    // Register number, rd / rj / rk fields
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    // One memory answer, lower word at the even word address
    typedef logic [`CORE_FETCH_WIDTH*32-1:0] fetch_pair_t;

    // Instruction buffer slot
    typedef struct packed {
        logic   valid;  // Slot carries an instruction on the fetch path
        addr_t  pc;
        instr_t instr;
    } ib_entry_t;

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_unit
    import core_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              imem_valid_i,
    input  fetch_pair_t                       imem_data_i,
    input  logic                              ib_stall_i,
    input  logic                              redirect_i,
    input  addr_t                             redirect_pc_i,
    output logic                              imem_req_o,
    output addr_t                             imem_addr_o,
    output logic                              fetch_valid_o,
    output ib_entry_t [`CORE_FETCH_WIDTH-1:0] fetch_entries_o
);

    localparam int PAIR_BYTES = `CORE_FETCH_WIDTH * 4;
    localparam int PAIR_LSB   = $clog2(PAIR_BYTES);
    localparam int WORD_LSB   = 2;

    addr_t pc_q;           // Next instruction on the fetch path
    addr_t pair_base;
    logic  req_q;
    logic  outstanding_q;  // Memory still owes an answer
    logic  stale_q;        // That answer belongs to a path left by a redirect
    logic  issue;
    logic  data_ok;

    assign pair_base = {pc_q[`CORE_XLEN-1:PAIR_LSB], {PAIR_LSB{1'b0}}};

    // One request in flight, and only with room for a full pair
    assign issue   = !req_q && !outstanding_q && !ib_stall_i && !redirect_i;
    assign data_ok = imem_valid_i && !stale_q && !redirect_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= `CORE_RESET_PC;
            req_q         <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            req_q <= issue;

            if (req_q) begin
                outstanding_q <= 1'b1;
            end else if (imem_valid_i) begin
                outstanding_q <= 1'b0;
            end

            if (redirect_i) begin
                pc_q    <= redirect_pc_i;
                // Anything already requested is now off path
                stale_q <= req_q || (outstanding_q && !imem_valid_i);
            end else if (imem_valid_i) begin
                stale_q <= 1'b0;
                if (!stale_q) begin
                    pc_q <= pair_base + addr_t'(PAIR_BYTES);  // Next pair boundary
                end
            end
        end
    end

    // Entries are built straight from the memory answer
    always_comb begin
        for (int i = 0; i < `CORE_FETCH_WIDTH; i++) begin
            fetch_entries_o[i].pc    = pair_base + addr_t'(4 * i);
            fetch_entries_o[i].instr = imem_data_i[32*i +: 32];
            // Words below the pc are skipped by an odd-word target
            fetch_entries_o[i].valid = data_ok &&
                                       (int'(pc_q[PAIR_LSB-1:WORD_LSB]) <= i);
        end
    end

    assign fetch_valid_o = data_ok;
    assign imem_req_o    = req_q;
    assign imem_addr_o   = pair_base;  // pc_q holds still while the request is pending

    // Memory may only answer the single pending request
    a_answer_pending : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        imem_valid_i |-> outstanding_q
    ) else $error("instruction memory answered with no request outstanding");

endmodule

// ==== logic/instr_buffer.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_buffer
    import core_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              fetch_valid_i,
    input  ib_entry_t [`CORE_FETCH_WIDTH-1:0] fetch_entries_i,
    input  logic                              ib_accept_i,
    input  logic                              flush_i,
    output logic                              ib_stall_o,
    output logic                              ib_valid_o,
    output ib_entry_t                         ib_entry_o
);

    localparam int DEPTH = `CORE_IB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    ib_entry_t mem_q [DEPTH];
    ptr_t      wr_ptr_q;
    ptr_t      rd_ptr_q;
    cnt_t      count_q;
    cnt_t      wr_cnt;                       // Valid slots in this fetch
    ptr_t      wr_idx [`CORE_FETCH_WIDTH];   // Target slot per fetch lane

    // Valid lanes are packed in lane order
    always_comb begin
        wr_cnt = '0;
        for (int i = 0; i < `CORE_FETCH_WIDTH; i++) begin
            wr_idx[i] = wr_ptr_q + ptr_t'(wr_cnt);
            if (fetch_valid_i && fetch_entries_i[i].valid) begin
                wr_cnt = wr_cnt + cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CORE_FETCH_WIDTH; i++) begin
            if (fetch_valid_i && fetch_entries_i[i].valid && !flush_i) begin
                mem_q[wr_idx[i]] <= fetch_entries_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Redirect drops everything, including this cycle's fetch
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(wr_cnt);
            rd_ptr_q <= rd_ptr_q + ptr_t'(ib_accept_i);
            count_q  <= count_q + wr_cnt - cnt_t'(ib_accept_i);
        end
    end

    assign ib_valid_o = (count_q != '0);

    // Keep room for the pair that may already be in flight
    assign ib_stall_o = count_q > cnt_t'(DEPTH - `CORE_FETCH_WIDTH);

    always_comb begin
        ib_entry_o       = mem_q[rd_ptr_q];
        ib_entry_o.valid = ib_valid_o;
    end

    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        count_q <= cnt_t'(DEPTH)
    ) else $error("instruction buffer overflow");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ib_accept_i |-> ib_valid_o
    ) else $error("instruction accepted from an empty buffer");

endmodule

// ==== logic/commit_unit.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module commit_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      ib_valid_i,
    input  ib_entry_t ib_entry_i,
    output logic      ib_accept_o,
    output logic      redirect_o,
    output addr_t     redirect_pc_o,
    output logic      dbg_wb_valid_o,
    output addr_t     dbg_wb_pc_o,
    output logic      dbg_wb_wen_o,
    output reg_idx_t  dbg_wb_wnum_o,
    output data_t     dbg_wb_wdata_o
);

    // LA32R major opcodes, each compared on its own field width
    localparam logic [9:0]  OP_ADDI_W  = 10'b0000001010;        // [31:22]
    localparam logic [16:0] OP_ADD_W   = 17'b00000000000100000; // [31:15]
    localparam logic [6:0]  OP_LU12I_W = 7'b0001010;            // [31:25]
    localparam logic [5:0]  OP_B       = 6'b010100;             // [31:26]

    instr_t   instr;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    data_t    rj_data;
    data_t    rk_data;
    data_t    imm_si12;
    data_t    imm_lu12i;
    addr_t    br_offs;
    logic     is_addi;
    logic     is_add;
    logic     is_lu12i;
    logic     is_b;
    logic     wr_op;
    logic     retire;
    logic     rf_we;
    data_t    result;
    data_t    regs_q [`CORE_NUM_REGS];

    assign instr = ib_entry_i.instr;
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign rk    = instr[14:10];

    assign is_addi  = (instr[31:22] == OP_ADDI_W);
    assign is_add   = (instr[31:15] == OP_ADD_W);
    assign is_lu12i = (instr[31:25] == OP_LU12I_W);
    assign is_b     = (instr[31:26] == OP_B);
    assign wr_op    = is_addi || is_add || is_lu12i;  // Unknown encodings fall through as no-ops

    assign imm_si12  = {{(`CORE_XLEN-12){instr[21]}}, instr[21:10]};
    assign imm_lu12i = {instr[24:5], 12'h000};
    // offs26 is split, high part sits in [9:0]
    assign br_offs   = {{(`CORE_XLEN-28){instr[9]}}, instr[9:0], instr[25:10], 2'b00};

    // r0 reads as zero
    assign rj_data = (rj == '0) ? '0 : regs_q[rj];
    assign rk_data = (rk == '0) ? '0 : regs_q[rk];

    always_comb begin
        result = '0;
        if (is_addi) begin
            result = rj_data + imm_si12;
        end else if (is_add) begin
            result = rj_data + rk_data;
        end else if (is_lu12i) begin
            result = imm_lu12i;
        end
    end

    // One instruction per cycle, whenever the buffer has one
    assign ib_accept_o = ib_valid_i;
    assign retire      = ib_valid_i && ib_entry_i.valid;
    assign rf_we       = retire && wr_op && (rd != '0);

    assign redirect_o    = retire && is_b;
    assign redirect_pc_o = ib_entry_i.pc + br_offs;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf_we) begin
            regs_q[rd] <= result;  // Next instruction sees it, no bypass needed
        end
    end

    // Debug writeback, one cycle behind the accept
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dbg_wb_valid_o <= 1'b0;
            dbg_wb_wen_o   <= 1'b0;
        end else begin
            dbg_wb_valid_o <= retire;
            dbg_wb_wen_o   <= rf_we;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            dbg_wb_pc_o    <= ib_entry_i.pc;
            dbg_wb_wnum_o  <= wr_op ? rd : '0;
            dbg_wb_wdata_o <= result;
        end
    end

    // Target feeds both fetch and buffer flush
    a_redirect_aligned : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> (redirect_pc_o[1:0] == 2'b00)
    ) else $error("branch target is not word aligned");

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    output logic        imem_req_o,
    output addr_t       imem_addr_o,
    input  logic        imem_valid_i,
    input  fetch_pair_t imem_data_i,
    output logic        dbg_wb_valid_o,
    output addr_t       dbg_wb_pc_o,
    output logic        dbg_wb_wen_o,
    output reg_idx_t    dbg_wb_wnum_o,
    output data_t       dbg_wb_wdata_o
);

    // Fetch to buffer
    logic                              fetch_valid;
    ib_entry_t [`CORE_FETCH_WIDTH-1:0] fetch_entries;
    logic                              ib_stall;

    // Buffer to commit
    logic      ib_valid;
    ib_entry_t ib_entry;
    logic      ib_accept;

    // Taken branch, also flushes the buffer
    logic  redirect;
    addr_t redirect_pc;

    fetch_unit u_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .imem_valid_i   (imem_valid_i),
        .imem_data_i    (imem_data_i),
        .ib_stall_i     (ib_stall),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .fetch_valid_o  (fetch_valid),
        .fetch_entries_o(fetch_entries)
    );

    instr_buffer u_ib (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_entries_i(fetch_entries),
        .ib_accept_i    (ib_accept),
        .flush_i        (redirect),
        .ib_stall_o     (ib_stall),
        .ib_valid_o     (ib_valid),
        .ib_entry_o     (ib_entry)
    );

    commit_unit u_commit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ib_valid_i    (ib_valid),
        .ib_entry_i    (ib_entry),
        .ib_accept_o   (ib_accept),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .dbg_wb_valid_o(dbg_wb_valid_o),
        .dbg_wb_pc_o   (dbg_wb_pc_o),
        .dbg_wb_wen_o  (dbg_wb_wen_o),
        .dbg_wb_wnum_o (dbg_wb_wnum_o),
        .dbg_wb_wdata_o(dbg_wb_wdata_o)
    );

endmodule

// ==== dv/tb_core_top.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core_top
    import core_pkg::*;
();

    localparam int NUM_COMMITS    = 60;
    localparam int PROG_WORDS     = 20;
    localparam int REQ_TIMEOUT    = 100;   // Cycles without a memory request
    localparam int COMMIT_TIMEOUT = 200;   // Cycles without a retired instruction
    localparam int RUN_TIMEOUT    = 3000;

    // LA32R opcode fields
    localparam logic [9:0]  OPC_ADDI  = 10'b0000001010;
    localparam logic [16:0] OPC_ADD   = 17'b00000000000100000;
    localparam logic [6:0]  OPC_LU12I = 7'b0001010;
    localparam logic [5:0]  OPC_B     = 6'b010100;
    localparam instr_t      SELF_LOOP = {OPC_B, 26'h0};  // B to itself

    logic        clk;
    logic        rst_n_i;
    logic        imem_req_o;
    addr_t       imem_addr_o;
    logic        imem_valid_i;
    fetch_pair_t imem_data_i;
    logic        dbg_wb_valid_o;
    addr_t       dbg_wb_pc_o;
    logic        dbg_wb_wen_o;
    reg_idx_t    dbg_wb_wnum_o;
    data_t       dbg_wb_wdata_o;

    instr_t   prog_mem [32];
    int       commit_count;

    // ISA model state
    addr_t    ref_pc;
    data_t    ref_regs [32];
    addr_t    exp_pc;
    logic     exp_wen;
    reg_idx_t exp_wnum;
    data_t    exp_wdata;

    core_top UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_valid_i  (imem_valid_i),
        .imem_data_i   (imem_data_i),
        .dbg_wb_valid_o(dbg_wb_valid_o),
        .dbg_wb_pc_o   (dbg_wb_pc_o),
        .dbg_wb_wen_o  (dbg_wb_wen_o),
        .dbg_wb_wnum_o (dbg_wb_wnum_o),
        .dbg_wb_wdata_o(dbg_wb_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic instr_t enc_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] si12);
        return {OPC_ADDI, si12, rj, rd};
    endfunction

    function automatic instr_t enc_add(reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {OPC_ADD, rk, rj, rd};
    endfunction

    function automatic instr_t enc_lu12i(reg_idx_t rd, logic [19:0] si20);
        return {OPC_LU12I, si20, rd};
    endfunction

    // Word offset, high ten bits go in the low field
    function automatic instr_t enc_b(logic [25:0] offs);
        return {OPC_B, offs[15:0], offs[25:16]};
    endfunction

    task automatic load_program();
        prog_mem[0]  = enc_addi(5'd1, 5'd0, 12'd5);
        prog_mem[1]  = enc_addi(5'd2, 5'd1, 12'hffd);      // -3
        prog_mem[2]  = enc_lu12i(5'd3, 20'h12345);
        prog_mem[3]  = enc_add(5'd4, 5'd3, 5'd1);
        prog_mem[4]  = enc_addi(5'd0, 5'd1, 12'd7);        // Discarded write to r0
        prog_mem[5]  = enc_add(5'd5, 5'd0, 5'd2);
        prog_mem[6]  = enc_b(26'd7);                       // Forward to word 13
        prog_mem[7]  = enc_addi(5'd6, 5'd0, 12'h111);      // Never retires
        prog_mem[8]  = enc_addi(5'd6, 5'd0, 12'h222);      // Never retires
        prog_mem[9]  = enc_addi(5'd8, 5'd7, 12'd2);
        prog_mem[10] = enc_add(5'd9, 5'd8, 5'd4);
        prog_mem[11] = enc_b(26'd5);                       // Forward to word 16
        prog_mem[12] = enc_addi(5'd6, 5'd0, 12'h333);      // Never retires
        prog_mem[13] = enc_addi(5'd7, 5'd0, 12'hfff);
        prog_mem[14] = enc_lu12i(5'd10, 20'hfffff);
        prog_mem[15] = enc_b(-26'sd6);                     // Back to odd word 9
        prog_mem[16] = enc_add(5'd11, 5'd10, 5'd9);
        prog_mem[17] = enc_addi(5'd12, 5'd11, 12'h7ff);
        prog_mem[18] = enc_add(5'd0, 5'd12, 5'd12);
        prog_mem[19] = enc_add(5'd13, 5'd0, 5'd12);
    endtask

    // Past the program every word is a self-loop
    function automatic instr_t mem_word(addr_t addr);
        addr_t offs;
        offs = addr - addr_t'(`CORE_RESET_PC);
        if (offs < addr_t'(PROG_WORDS * 4)) begin
            return prog_mem[offs[6:2]];
        end
        return SELF_LOOP;
    endfunction

    // Executes the instruction at ref_pc and sets the expected writeback
    function automatic void step_reference();
        instr_t              ins;
        reg_idx_t            rd;
        data_t               src_j;
        data_t               src_k;
        logic signed [25:0]  offs;
        addr_t               br_offs;
        logic                writes;
        addr_t               next_pc;
        ins     = mem_word(ref_pc);
        rd      = ins[4:0];
        src_j   = ref_regs[ins[9:5]];
        src_k   = ref_regs[ins[14:10]];
        writes  = 1'b0;
        next_pc = ref_pc + addr_t'(4);
        exp_pc    = ref_pc;
        exp_wen   = 1'b0;
        exp_wnum  = '0;
        exp_wdata = '0;
        if (ins[31:26] == OPC_B) begin
            offs    = {ins[9:0], ins[25:10]};
            br_offs = addr_t'(offs);
            next_pc = ref_pc + (br_offs << 2);
        end else if (ins[31:22] == OPC_ADDI) begin
            exp_wdata = src_j + data_t'($signed(ins[21:10]));
            writes    = 1'b1;
        end else if (ins[31:15] == OPC_ADD) begin
            exp_wdata = src_j + src_k;
            writes    = 1'b1;
        end else if (ins[31:25] == OPC_LU12I) begin
            exp_wdata = {ins[24:5], 12'h000};
            writes    = 1'b1;
        end
        if (writes && rd != 5'd0) begin
            exp_wen       = 1'b1;
            exp_wnum      = rd;
            ref_regs[rd]  = exp_wdata;
        end
        ref_pc = next_pc;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic timeout_failure(string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(string what, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_data(string what, data_t got, data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Reset, first request and the overall run limit
    initial begin
        int cycles;
        rst_n_i      = 1'b0;
        imem_valid_i = 1'b0;
        imem_data_i  = '0;
        commit_count = 0;
        load_program();

        // Two rising edges with reset held
        repeat (2) begin
            @(posedge clk);
            #1;
            check_flag("imem_req_o in reset", imem_req_o, 1'b0);
            check_flag("dbg_wb_valid_o in reset", dbg_wb_valid_o, 1'b0);
            check_flag("dbg_wb_wen_o in reset", dbg_wb_wen_o, 1'b0);
        end
        rst_n_i = 1'b1;

        @(negedge clk);
        check_flag("imem_req_o after reset", imem_req_o, 1'b0);
        check_flag("dbg_wb_valid_o after reset", dbg_wb_valid_o, 1'b0);
        check_flag("dbg_wb_wen_o after reset", dbg_wb_wen_o, 1'b0);

        cycles = 0;
        while (imem_req_o !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                timeout_failure("Timeout: no instruction request after reset");
            end
        end
        check_addr("first request address", imem_addr_o, `CORE_RESET_PC);

        cycles = 0;
        while (commit_count < NUM_COMMITS && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (commit_count >= NUM_COMMITS) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Timeout: only %0d of %0d instructions retired", commit_count,
                     NUM_COMMITS);
            stop_with_failure();
        end
    end

    // Instruction memory, one answer per request with random latency
    initial begin
        int    lat;
        int    idle;
        addr_t req_addr;
        void'($urandom(32'h0f540f8e));
        idle = 0;
        while (rst_n_i !== 1'b1) begin
            @(negedge clk);
            idle++;
            if (idle > REQ_TIMEOUT) begin
                timeout_failure("Timeout: reset never released for the memory model");
            end
        end
        idle = 0;
        forever begin
            @(negedge clk);
            if (imem_req_o) begin
                idle     = 0;
                req_addr = imem_addr_o;
                lat      = $urandom_range(6, 1);
                repeat (lat) @(posedge clk);
                #1;
                imem_valid_i = 1'b1;
                imem_data_i  = {mem_word(req_addr + addr_t'(4)), mem_word(req_addr)};
                @(posedge clk);
                #1 imem_valid_i = 1'b0;
            end else begin
                idle++;
                if (idle > REQ_TIMEOUT) begin
                    timeout_failure("Timeout: fetch stopped requesting instructions");
                end
            end
        end
    end

    // Compares each retired instruction with the ISA model
    initial begin
        int idle;
        ref_pc = `CORE_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        idle = 0;
        while (rst_n_i !== 1'b1) begin
            @(negedge clk);
            idle++;
            if (idle > REQ_TIMEOUT) begin
                timeout_failure("Timeout: reset never released for the checker");
            end
        end
        idle = 0;
        forever begin
            @(negedge clk);
            if (dbg_wb_valid_o) begin
                idle = 0;
                step_reference();
                check_addr("retired pc", dbg_wb_pc_o, exp_pc);
                check_flag("dbg_wb_wen_o", dbg_wb_wen_o, exp_wen);
                if (exp_wen) begin
                    check_reg("dbg_wb_wnum_o", dbg_wb_wnum_o, exp_wnum);
                    check_data("dbg_wb_wdata_o", dbg_wb_wdata_o, exp_wdata);
                end
                commit_count++;
            end else begin
                idle++;
                if (idle > COMMIT_TIMEOUT) begin
                    timeout_failure("Timeout: no instruction retired for too long");
                end
            end
        end
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/core_pkg.sv
logic/fetch_unit.sv
logic/instr_buffer.sv
logic/commit_unit.sv
logic/core_top.sv
dv/tb_core_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_core_top_sim
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_core_top \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "TEST RESULT: FAIL" "$LOG_FILE"; then
    echo "Simulation reported a failure, see $LOG_FILE"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
